/* runSim.sh */
#!/bin/sh
# Build and run the video transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbVideoTx \
	-Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/VtbVideoTx)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

/* sim.f */
source/csrMapPkg.sv
source/videoPkg.sv
source/videoTxCsr.sv
source/videoDmaAdrsGen.sv
source/sceneFade.sv
source/videoTxTop.sv
sim/tbVideoTx.sv

/* sim/tbVideoTx.sv */
/*
 * Testbench for the video transmit subsystem
 * Drives the register bus, pixel requests, frame ticks and a random
 * pixel stream, and checks reads, DMA addresses and blended pixels
 */
`default_nettype none

module tbVideoTx;
	timeunit 1ns;
	timeprecision 100ps;

	logic iSCLK;
	logic iSRST;
	logic [31:0] usiAdrs, usiWd, usiRd;
	logic frameTick, pixelReq, pixelValid;
	logic [15:0] pixelData, pixelOut;
	logic [18:0] dmaAdrs;
	logic dmaAdrsValid, pixelOutValid;
	logic [7:0] mapXSize, mapYSize;

	logic [15:0] lfsr = 16'd74;
	int errCount = 0;
	int testCount = 0;
	int testFails = 0;
	logic [15:0] pixQ[$];
	logic streamOn = 1'b0;
	logic [15:0] colorModel = '0;
	logic [4:0] modelAlpha = '0;		// Alpha as the fade rule predicts it
	logic [4:0] alphaLast = '0;
	logic validLast = 1'b0;
	int modelCnt = 0;
	int modelTiming = 0;
	logic modelAdd = 1'b0, modelSub = 1'b0;

	videoTxTop uut
	(
		.iSCLK(iSCLK), .iSRST(iSRST),
		.usiAdrs(usiAdrs), .usiWd(usiWd), .usiRd(usiRd),
		.frameTick(frameTick), .pixelReq(pixelReq),
		.pixelData(pixelData), .pixelValid(pixelValid),
		.dmaAdrs(dmaAdrs), .dmaAdrsValid(dmaAdrsValid),
		.pixelOut(pixelOut), .pixelOutValid(pixelOutValid),
		.mapXSize(mapXSize), .mapYSize(mapYSize)
	);

	always #2 iSCLK = ~iSCLK;

	//------------------------------------------------------------
	// Random bits and reference model
	//------------------------------------------------------------
	// Taps x^16 + x^14 + x^13 + x^11 stepped once per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[15]};
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
		return v;
	endfunction

	// Each channel is (pix * (16 - a) + col * a) / 16
	function automatic logic [15:0] blendRef(input logic [15:0] pix, input logic [15:0] col,
		input int a);
		int r, g, b;
		r = (pix[15:11] * (16 - a) + col[15:11] * a) / 16;
		g = (pix[10:5] * (16 - a) + col[10:5] * a) / 16;
		b = (pix[4:0] * (16 - a) + col[4:0] * a) / 16;
		return {r[4:0], g[5:0], b[4:0]};
	endfunction

	function automatic logic [31:0] busWord(input logic wr, input logic [7:0] blk,
		input logic [15:0] off);
		return {1'b0, wr, 6'b0, blk, off};
	endfunction

	//------------------------------------------------------------
	// Bus, DMA and frame tasks
	//------------------------------------------------------------
	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else
		begin
			errCount++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic regWrite(input logic [15:0] off, input logic [31:0] data,
		input logic [7:0] blk = csrMapPkg::csrBlockId);
		@(posedge iSCLK);
		usiAdrs <= busWord(1'b1, blk, off);
		usiWd <= data;
		@(posedge iSCLK);
		usiAdrs <= busWord(1'b0, blk, off);		// Strobe low again
	endtask

	task automatic regRead(input logic [15:0] off, input logic [31:0] wd,
		input logic [31:0] exp, input string what);
		@(posedge iSCLK);
		usiAdrs <= busWord(1'b0, csrMapPkg::csrBlockId, off);
		usiWd <= wd;
		@(posedge iSCLK);
		@(negedge iSCLK);
		checkEq(usiRd, exp, what);
	endtask

	task automatic dmaRequest(output logic got, output logic [18:0] adrs);
		@(posedge iSCLK);
		pixelReq <= 1'b1;
		@(posedge iSCLK);
		pixelReq <= 1'b0;
		got = 1'b0;
		adrs = '0;
		for (int t = 0; t < 4 && !got; t++)
		begin
			@(negedge iSCLK);
			if (dmaAdrsValid)
			begin
				got = 1'b1;
				adrs = dmaAdrs;
			end
		end
	endtask

	task automatic dmaExpect(input logic [18:0] exp);
		logic got;
		logic [18:0] adrs;
		dmaRequest(got, adrs);
		if (!got)
		begin
			errCount++;
			$display("Timed out waiting for a DMA address after a pixel request");
		end
		else
			checkEq(32'(adrs), 32'(exp), "DMA address");
	endtask

	task automatic frameStep;
		@(posedge iSCLK);
		frameTick <= 1'b1;
		@(posedge iSCLK);
		frameTick <= 1'b0;
		if (modelAdd || modelSub)
		begin
			if (modelCnt == modelTiming)
			begin
				modelCnt = 0;
				if (modelAdd && modelAlpha != 16)
					modelAlpha = modelAlpha + 1;
				else if (!modelAdd && modelAlpha != 0)
					modelAlpha = modelAlpha - 1;
			end
			else
				modelCnt++;
		end
	endtask

	task automatic statusStep;
		frameStep();
		regRead(csrMapPkg::adrSceneStatus, 0,
			32'({modelAlpha == 16, modelAlpha == 0}), "scene status");
	endtask

	task automatic testDone(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore)
			$display("Test %0d %s: passed", testCount, name);
		else
		begin
			testFails++;
			$display("Test %0d %s: failed", testCount, name);
		end
	endtask

	//------------------------------------------------------------
	// Pixel stream and compare
	//------------------------------------------------------------
	always @(posedge iSCLK)
	begin : stream
		logic v;
		logic [15:0] d;
		if (streamOn)
		begin
			v = randBits(1);
			d = randBits(16);
			pixelValid <= v;
			pixelData <= d;
			if (v)
				pixQ.push_back(d);
		end
		else
			pixelValid <= 1'b0;
	end

	// Alpha seen here at the previous negedge is what the blend used
	always @(negedge iSCLK)
	begin : compare
		logic [15:0] pix;
		if (!iSRST)
		begin
			assert (pixelOutValid === validLast)
			else
			begin
				errCount++;
				$display("ERROR %0t: pixel valid not one clock after input", $time);
			end
			if (pixelOutValid)
			begin
				if (pixQ.size() == 0)
				begin
					errCount++;
					$display("Blended pixel came out with no pixel sent in");
				end
				else
				begin
					pix = pixQ.pop_front();
					checkEq(32'(pixelOut), 32'(blendRef(pix, colorModel, alphaLast)),
						"blended pixel");
				end
			end
		end
		validLast = pixelValid;
		alphaLast = modelAlpha;
	end

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------
	initial
	begin : main
		int e;
		logic [31:0] v;
		logic got;
		logic [18:0] adrs;
		iSCLK = 1'b0;
		iSRST = 1'b1;
		usiAdrs = '0;
		usiWd = '0;
		frameTick = 1'b0;
		pixelReq = 1'b0;
		pixelData = '0;
		pixelValid = 1'b0;
		repeat (5) @(posedge iSCLK);
		iSRST <= 1'b0;

		e = errCount;
		regRead(csrMapPkg::adrDmaEnable, 0, 0, "reset DMA enable");
		regRead(csrMapPkg::adrDmaEnd, 0, 32'h7FFFF, "reset DMA end");
		checkEq(32'(mapXSize), 30, "reset map X");
		checkEq(32'(mapYSize), 17, "reset map Y");
		regRead(csrMapPkg::adrSceneCtrl, 0, 4, "reset scene control");
		regRead(csrMapPkg::adrSceneStatus, 0, 1, "reset scene status");
		testDone("reset values", e);

		e = errCount;
		v = randBits(32);
		regWrite(csrMapPkg::adrDmaEnable, v);
		regRead(csrMapPkg::adrDmaEnable, 0, v & 32'h1, "DMA enable");
		v = randBits(32);
		regWrite(csrMapPkg::adrDmaCycle, v);
		regRead(csrMapPkg::adrDmaCycle, 0, v & 32'h1, "DMA cycle");
		v = randBits(32);
		regWrite(csrMapPkg::adrDmaStart, v);
		regRead(csrMapPkg::adrDmaStart, 0, v & 32'h7FFFF, "DMA start");
		regWrite(csrMapPkg::adrDmaStart, ~v, 8'h05);		// Other block number
		regRead(csrMapPkg::adrDmaStart, 0, v & 32'h7FFFF, "DMA start after foreign write");
		v = randBits(32);
		regWrite(csrMapPkg::adrDmaEnd, v);
		regRead(csrMapPkg::adrDmaEnd, 0, v & 32'h7FFFF, "DMA end");
		v = randBits(32);
		regWrite(csrMapPkg::adrDmaAdd, v);
		regRead(csrMapPkg::adrDmaAdd, 0, v & 32'h7FFFF, "DMA step");
		v = randBits(32);
		regWrite(csrMapPkg::adrMapSize, v);
		regRead(csrMapPkg::adrMapSize, 0, v & 32'hFFFF, "map size");
		checkEq(32'(mapXSize), 32'(v[15:8]), "map X");
		checkEq(32'(mapYSize), 32'(v[7:0]), "map Y");
		v = randBits(32);
		regWrite(csrMapPkg::adrSceneColor, v);
		regRead(csrMapPkg::adrSceneColor, 0, v & 32'hFFFF, "scene colour");
		v = randBits(32);
		regWrite(csrMapPkg::adrSceneTiming, v);
		regRead(csrMapPkg::adrSceneTiming, 0, v & 32'h7F, "scene timing");
		v = randBits(32);
		regWrite(csrMapPkg::adrSceneCtrl, v);
		regRead(csrMapPkg::adrSceneCtrl, 0, v & 32'h7, "scene control");
		v = randBits(32);
		regRead(16'h0100, v, v, "unmapped read");
		regWrite(csrMapPkg::adrSceneCtrl, 4);
		regWrite(csrMapPkg::adrDmaEnable, 0);
		testDone("register access", e);

		// Single shot 0x100 to 0x140 in steps of 0x10
		e = errCount;
		regWrite(csrMapPkg::adrDmaCycle, 0);
		regWrite(csrMapPkg::adrDmaStart, 32'h100);
		regWrite(csrMapPkg::adrDmaEnd, 32'h140);
		regWrite(csrMapPkg::adrDmaAdd, 32'h10);
		regWrite(csrMapPkg::adrDmaEnable, 1);
		for (int a = 32'h100; a <= 32'h140; a += 32'h10)
			dmaExpect(a);
		regRead(csrMapPkg::adrDmaEnable, 0, 0, "DMA enable after single shot");
		dmaRequest(got, adrs);
		assert (!got)
		else
		begin
			errCount++;
			$display("ERROR %0t: DMA address issued while disabled", $time);
		end
		testDone("single-shot DMA", e);

		e = errCount;
		regWrite(csrMapPkg::adrDmaCycle, 1);
		regWrite(csrMapPkg::adrDmaEnable, 1);
		for (int pass = 0; pass < 2; pass++)
			for (int a = 32'h100; a <= 32'h140; a += 32'h10)
				dmaExpect(a);
		dmaExpect(19'h100);
		regRead(csrMapPkg::adrDmaEnable, 0, 1, "DMA enable in cyclic mode");
		regWrite(csrMapPkg::adrDmaEnable, 0);
		regWrite(csrMapPkg::adrDmaCycle, 0);
		testDone("cyclic DMA", e);

		// Fade with N = 2 and pixels streamed all along
		e = errCount;
		colorModel = randBits(16);
		regWrite(csrMapPkg::adrSceneColor, 32'(colorModel));
		regWrite(csrMapPkg::adrSceneTiming, 2);
		modelTiming = 2;
		@(negedge iSCLK);
		streamOn = 1'b1;
		regWrite(csrMapPkg::adrSceneCtrl, 1);
		modelAdd = 1'b1;
		modelCnt = 0;
		for (int i = 0; i < 17 * 3; i++)
			statusStep();
		regRead(csrMapPkg::adrSceneStatus, 0, 2, "scene status at max");
		regWrite(csrMapPkg::adrSceneCtrl, 2);
		modelAdd = 1'b0;
		modelSub = 1'b1;
		for (int i = 0; i < 17 * 3; i++)
			statusStep();
		regRead(csrMapPkg::adrSceneStatus, 0, 1, "scene status at min");
		streamOn = 1'b0;
		for (int t = 0; t < 10 && pixQ.size() != 0; t++)
			@(negedge iSCLK);
		if (pixQ.size() != 0)
		begin
			errCount++;
			$display("Timed out waiting for the last blended pixels");
		end
		testDone("scene fade", e);

		$display("Tests %0d, failed %0d, errors %0d", testCount, testFails, errCount);
		if (errCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* source/csrMapPkg.sv */
/*
 * CSR map for the video transmit block
 * Register bus widths, the write strobe position, the block number
 * and the offset of every register in the block
 */
`default_nettype none

package csrMapPkg;

	//------------------------------------------------------------
	// Register bus
	//------------------------------------------------------------
	localparam int usiBusWidth = 32;
	localparam int usiWriteBit = 30;				// Write strobe, plain level
	localparam logic [7:0] csrBlockId = 8'h04;		// Matched against address 23:16
	localparam int csrOffsetWidth = 16;

	//------------------------------------------------------------
	// Register offsets
	//------------------------------------------------------------
	// DMA address generator
	localparam logic [15:0] adrDmaEnable = 16'h0004;
	localparam logic [15:0] adrDmaCycle = 16'h0008;
	localparam logic [15:0] adrDmaStart = 16'h000C;
	localparam logic [15:0] adrDmaEnd = 16'h0010;
	localparam logic [15:0] adrDmaAdd = 16'h0014;

	// Map chip size, X in the upper byte
	localparam logic [15:0] adrMapSize = 16'h0200;

	// Scene change fade
	localparam logic [15:0] adrSceneColor = 16'h0300;
	localparam logic [15:0] adrSceneTiming = 16'h0304;
	localparam logic [15:0] adrSceneCtrl = 16'h0308;	// Bit 0 add, bit 1 sub, bit 2 reset
	localparam logic [15:0] adrSceneStatus = 16'h030C;	// Bit 1 alpha max, bit 0 alpha min

endpackage

`default_nettype wire

/* source/sceneFade.sv */
/*
 * Scene change fade engine
 * Divides the frame tick by a programmable count to step a saturating
 * alpha, then blends each RGB565 pixel toward the scene colour by
 * alpha / 16 in one register stage
 */
`default_nettype none

module sceneFade
(
	input  logic iSCLK,
	input  logic iSRST,
	input  logic frameTick,
	input  logic [videoPkg::colorDepth-1:0] sceneColor,
	input  logic [videoPkg::frameTimingWidth-1:0] frameTiming,
	input  logic addEn,
	input  logic subEn,
	input  logic sceneRst,
	input  logic [videoPkg::colorDepth-1:0] pixelData,
	input  logic pixelValid,
	output logic [videoPkg::colorDepth-1:0] pixelOut,
	output logic pixelOutValid,
	output logic alphaMax,
	output logic alphaMin
);

	logic [videoPkg::frameTimingWidth-1:0] frameCnt;
	logic [videoPkg::alphaWidth-1:0] alpha;
	logic [5:0] mixR, mixG, mixB;

	// Weighted mix of one channel, widest channel is green
	function automatic logic [5:0] blendChan(input logic [5:0] pix, input logic [5:0] col,
		input logic [videoPkg::alphaWidth-1:0] a);
		logic [11:0] mix;
		mix = 12'(pix) * 12'(videoPkg::alphaFull - a) + 12'(col) * 12'(a);
		return mix[9:4];
	endfunction

	//------------------------------------------------------------
	// Frame divider and alpha ramp
	//------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || sceneRst)
		begin
			frameCnt <= '0;
			alpha <= '0;
		end
		else if (frameTick && (addEn || subEn))
		begin
			if (frameCnt == frameTiming)
			begin
				frameCnt <= '0;
				if (addEn)
				begin
					if (alpha != videoPkg::alphaFull)
						alpha <= alpha + 1'b1;
				end
				else if (alpha != '0)
					alpha <= alpha - 1'b1;
			end
			else
				frameCnt <= frameCnt + 1'b1;
		end
	end

	// Status flags, one clock behind alpha
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			alphaMax <= 1'b0;
			alphaMin <= 1'b1;
		end
		else
		begin
			alphaMax <= (alpha == videoPkg::alphaFull);
			alphaMin <= (alpha == '0);
		end
	end

	//------------------------------------------------------------
	// Pixel blend
	//------------------------------------------------------------
	// R 15:11, G 10:5, B 4:0
	assign mixR = blendChan({1'b0, pixelData[15:11]}, {1'b0, sceneColor[15:11]}, alpha);
	assign mixG = blendChan(pixelData[10:5], sceneColor[10:5], alpha);
	assign mixB = blendChan({1'b0, pixelData[4:0]}, {1'b0, sceneColor[4:0]}, alpha);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			pixelOutValid <= 1'b0;
		else
			pixelOutValid <= pixelValid;
	end

	always_ff @(posedge iSCLK)
	begin
		if (pixelValid)
			pixelOut <= {mixR[4:0], mixG, mixB[4:0]};	// Top bit of R and B stays zero
	end

	assert property (@(posedge iSCLK) disable iff (iSRST) alpha <= videoPkg::alphaFull)
		else $error("Alpha above full scale");

endmodule

`default_nettype wire

/* source/videoDmaAdrsGen.sv */
/*
 * Frame-buffer DMA address generator
 * Issues one address per pixel request from start in fixed steps,
 * pulses done with the last address that does not pass the end
 * and reloads the start for the next pass
 */
`default_nettype none

module videoDmaAdrsGen
(
	input  logic iSCLK,
	input  logic iSRST,
	input  logic enable,
	input  logic [videoPkg::dmaAdrsWidth-1:0] adrsStart,
	input  logic [videoPkg::dmaAdrsWidth-1:0] adrsEnd,
	input  logic [videoPkg::dmaAdrsWidth-1:0] adrsAdd,
	input  logic pixelReq,
	output logic [videoPkg::dmaAdrsWidth-1:0] dmaAdrs,
	output logic dmaAdrsValid,
	output logic dmaDone
);

	logic enableDly;
	logic enRise;
	logic issue;
	logic lastAdrs;
	logic [videoPkg::dmaAdrsWidth-1:0] curAdrs;
	logic [videoPkg::dmaAdrsWidth-1:0] issueAdrs;
	logic [videoPkg::dmaAdrsWidth:0] nextAdrs;		// One spare bit for the end compare

	//------------------------------------------------------------
	// Next address and end detection
	//------------------------------------------------------------
	assign enRise = enable && !enableDly;
	assign issue = enable && pixelReq;
	assign issueAdrs = enRise ? adrsStart : curAdrs;	// First request may meet the edge
	assign nextAdrs = {1'b0, issueAdrs} + {1'b0, adrsAdd};
	assign lastAdrs = nextAdrs > {1'b0, adrsEnd};

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			enableDly <= 1'b0;
			dmaAdrsValid <= 1'b0;
			dmaDone <= 1'b0;
		end
		else
		begin
			enableDly <= enable;
			dmaAdrsValid <= issue;
			dmaDone <= issue && lastAdrs;
		end
	end

	// Running address
	always_ff @(posedge iSCLK)
	begin
		if (issue)
		begin
			dmaAdrs <= issueAdrs;
			curAdrs <= lastAdrs ? adrsStart : nextAdrs[videoPkg::dmaAdrsWidth-1:0];
		end
		else if (enRise)
			curAdrs <= adrsStart;
	end

	// Done marks an issued address with no room left for another step
	assert property (@(posedge iSCLK) disable iff (iSRST)
		dmaDone |-> dmaAdrsValid &&
			({1'b0, dmaAdrs} + {1'b0, adrsAdd} > {1'b0, adrsEnd}))
		else $error("DMA done without a last address");

endmodule

`default_nettype wire

/* source/videoPkg.sv */
/*
 * Video datapath definitions
 * Frame-buffer address width, RGB565 pixel and alpha sizes,
 * fade timing width and the map-size register word
 */
`default_nettype none

package videoPkg;

	//------------------------------------------------------------
	// Frame buffer and pixel format
	//------------------------------------------------------------
	localparam int dmaAdrsWidth = 19;
	localparam int colorDepth = 16;					// RGB565

	// Blend factor, 0 up to alphaFull
	localparam int alphaWidth = 5;
	localparam logic [alphaWidth-1:0] alphaFull = 5'd16;
	localparam int frameTimingWidth = 7;

	//------------------------------------------------------------
	// Map chip size
	//------------------------------------------------------------
	// 480 / 16 by 272 / 16 tiles
	localparam logic [7:0] mapXReset = 8'd30;
	localparam logic [7:0] mapYReset = 8'd17;

	typedef struct packed
	{
		logic [7:0] xSize;
		logic [7:0] ySize;
	} mapSizeFields;

	// Raw bus word or the two tile counts
	typedef union packed
	{
		logic [15:0] raw;
		mapSizeFields size;
	} mapSizeWord;

endpackage

`default_nettype wire

/* source/videoTxCsr.sv */
/*
 * Video transmit control/status registers
 * Decodes bus writes for this block into register write enables,
 * holds the DMA, map and scene registers, stops a single-shot DMA
 * when the generator reports done, and returns a registered read word
 */
`default_nettype none

module videoTxCsr
(
	input  logic iSCLK,
	input  logic iSRST,
	// Register bus
	input  logic [csrMapPkg::usiBusWidth-1:0] usiAdrs,
	input  logic [csrMapPkg::usiBusWidth-1:0] usiWd,
	output logic [csrMapPkg::usiBusWidth-1:0] usiRd,
	// DMA address generator
	output logic dmaEnable,
	output logic dmaCycleEnable,
	output logic [videoPkg::dmaAdrsWidth-1:0] dmaAdrsStart,
	output logic [videoPkg::dmaAdrsWidth-1:0] dmaAdrsEnd,
	output logic [videoPkg::dmaAdrsWidth-1:0] dmaAdrsAdd,
	input  logic dmaDone,
	// Map info
	output videoPkg::mapSizeWord mapSize,
	// Scene fade
	output logic [videoPkg::colorDepth-1:0] sceneColor,
	output logic [videoPkg::frameTimingWidth-1:0] sceneFrameTiming,
	output logic sceneAddEn,
	output logic sceneSubEn,
	output logic sceneRst,
	input  logic alphaMax,
	input  logic alphaMin
);

	logic wrHit;
	logic [csrMapPkg::csrOffsetWidth-1:0] offset;
	logic wrDmaEnable, wrDmaCycle, wrDmaStart, wrDmaEnd, wrDmaAdd;
	logic wrMapSize, wrSceneColor, wrSceneTiming, wrSceneCtrl;

	//------------------------------------------------------------
	// Write decode
	//------------------------------------------------------------
	assign offset = usiAdrs[csrMapPkg::csrOffsetWidth-1:0];
	assign wrHit = usiAdrs[csrMapPkg::usiWriteBit] &&
		(usiAdrs[csrMapPkg::csrOffsetWidth +: 8] == csrMapPkg::csrBlockId);

	assign wrDmaEnable = wrHit && (offset == csrMapPkg::adrDmaEnable);
	assign wrDmaCycle = wrHit && (offset == csrMapPkg::adrDmaCycle);
	assign wrDmaStart = wrHit && (offset == csrMapPkg::adrDmaStart);
	assign wrDmaEnd = wrHit && (offset == csrMapPkg::adrDmaEnd);
	assign wrDmaAdd = wrHit && (offset == csrMapPkg::adrDmaAdd);
	assign wrMapSize = wrHit && (offset == csrMapPkg::adrMapSize);
	assign wrSceneColor = wrHit && (offset == csrMapPkg::adrSceneColor);
	assign wrSceneTiming = wrHit && (offset == csrMapPkg::adrSceneTiming);
	assign wrSceneCtrl = wrHit && (offset == csrMapPkg::adrSceneCtrl);

	//------------------------------------------------------------
	// Register file
	//------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			dmaEnable <= 1'b0;
			dmaCycleEnable <= 1'b0;
			dmaAdrsStart <= '0;
			dmaAdrsEnd <= '1;
			dmaAdrsAdd <= '0;
			mapSize.size.xSize <= videoPkg::mapXReset;
			mapSize.size.ySize <= videoPkg::mapYReset;
			sceneColor <= '0;
			sceneFrameTiming <= '0;
			sceneAddEn <= 1'b0;
			sceneSubEn <= 1'b0;
			sceneRst <= 1'b1;			// Fade engine held until released
		end
		else
		begin
			// Single shot stops itself, cyclic mode keeps running
			if (dmaDone)
				dmaEnable <= dmaCycleEnable;
			else if (wrDmaEnable)
				dmaEnable <= usiWd[0];

			if (wrDmaCycle)
				dmaCycleEnable <= usiWd[0];
			if (wrDmaStart)
				dmaAdrsStart <= usiWd[videoPkg::dmaAdrsWidth-1:0];
			if (wrDmaEnd)
				dmaAdrsEnd <= usiWd[videoPkg::dmaAdrsWidth-1:0];
			if (wrDmaAdd)
				dmaAdrsAdd <= usiWd[videoPkg::dmaAdrsWidth-1:0];
			if (wrMapSize)
				mapSize.raw <= usiWd[15:0];
			if (wrSceneColor)
				sceneColor <= usiWd[videoPkg::colorDepth-1:0];
			if (wrSceneTiming)
				sceneFrameTiming <= usiWd[videoPkg::frameTimingWidth-1:0];
			if (wrSceneCtrl)
			begin
				sceneAddEn <= usiWd[0];
				sceneSubEn <= usiWd[1];
				sceneRst <= usiWd[2];
			end
		end
	end

	//------------------------------------------------------------
	// Registered read
	//------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		case (offset)
			csrMapPkg::adrDmaEnable:	usiRd <= 32'(dmaEnable);
			csrMapPkg::adrDmaCycle:		usiRd <= 32'(dmaCycleEnable);
			csrMapPkg::adrDmaStart:		usiRd <= 32'(dmaAdrsStart);
			csrMapPkg::adrDmaEnd:		usiRd <= 32'(dmaAdrsEnd);
			csrMapPkg::adrDmaAdd:		usiRd <= 32'(dmaAdrsAdd);
			csrMapPkg::adrMapSize:		usiRd <= 32'(mapSize.raw);
			csrMapPkg::adrSceneColor:	usiRd <= 32'(sceneColor);
			csrMapPkg::adrSceneTiming:	usiRd <= 32'(sceneFrameTiming);
			csrMapPkg::adrSceneCtrl:	usiRd <= 32'({sceneRst, sceneSubEn, sceneAddEn});
			csrMapPkg::adrSceneStatus:	usiRd <= 32'({alphaMax, alphaMin});
			default:					usiRd <= usiWd;		// Unmapped echoes write data
		endcase
	end

	// One register per write strobe clock
	assert property (@(posedge iSCLK) disable iff (iSRST)
		$onehot0({wrDmaEnable, wrDmaCycle, wrDmaStart, wrDmaEnd, wrDmaAdd,
			wrMapSize, wrSceneColor, wrSceneTiming, wrSceneCtrl}))
		else $error("CSR decoded more than one write enable");

endmodule

`default_nettype wire

/* source/videoTxTop.sv */
/*
 * Video transmit subsystem top
 * Register slave driving the frame-buffer DMA address generator
 * and the scene change fade engine
 */
`default_nettype none

module videoTxTop
(
	input  logic iSCLK,
	input  logic iSRST,
	// Register bus
	input  logic [csrMapPkg::usiBusWidth-1:0] usiAdrs,
	input  logic [csrMapPkg::usiBusWidth-1:0] usiWd,
	output logic [csrMapPkg::usiBusWidth-1:0] usiRd,
	// Display timing side
	input  logic frameTick,
	input  logic pixelReq,
	input  logic [videoPkg::colorDepth-1:0] pixelData,
	input  logic pixelValid,
	// Frame buffer address
	output logic [videoPkg::dmaAdrsWidth-1:0] dmaAdrs,
	output logic dmaAdrsValid,
	// Blended pixels
	output logic [videoPkg::colorDepth-1:0] pixelOut,
	output logic pixelOutValid,
	// To the map renderer
	output logic [7:0] mapXSize,
	output logic [7:0] mapYSize
);

	logic dmaEnable;
	logic dmaDone;
	logic [videoPkg::dmaAdrsWidth-1:0] dmaAdrsStart, dmaAdrsEnd, dmaAdrsAdd;
	videoPkg::mapSizeWord mapSize;
	logic [videoPkg::colorDepth-1:0] sceneColor;
	logic [videoPkg::frameTimingWidth-1:0] sceneFrameTiming;
	logic sceneAddEn, sceneSubEn, sceneRst;
	logic alphaMax, alphaMin;

	assign mapXSize = mapSize.size.xSize;
	assign mapYSize = mapSize.size.ySize;

	//------------------------------------------------------------
	// Engines and their register slave
	//------------------------------------------------------------
	videoTxCsr csr
	(
		.iSCLK(iSCLK), .iSRST(iSRST),
		.usiAdrs(usiAdrs), .usiWd(usiWd), .usiRd(usiRd),
		.dmaEnable(dmaEnable), .dmaCycleEnable(),		// Cycle bit only used inside
		.dmaAdrsStart(dmaAdrsStart), .dmaAdrsEnd(dmaAdrsEnd), .dmaAdrsAdd(dmaAdrsAdd),
		.dmaDone(dmaDone),
		.mapSize(mapSize),
		.sceneColor(sceneColor), .sceneFrameTiming(sceneFrameTiming),
		.sceneAddEn(sceneAddEn), .sceneSubEn(sceneSubEn), .sceneRst(sceneRst),
		.alphaMax(alphaMax), .alphaMin(alphaMin)
	);

	videoDmaAdrsGen dmaGen
	(
		.iSCLK(iSCLK), .iSRST(iSRST),
		.enable(dmaEnable),
		.adrsStart(dmaAdrsStart), .adrsEnd(dmaAdrsEnd), .adrsAdd(dmaAdrsAdd),
		.pixelReq(pixelReq),
		.dmaAdrs(dmaAdrs), .dmaAdrsValid(dmaAdrsValid), .dmaDone(dmaDone)
	);

	sceneFade fade
	(
		.iSCLK(iSCLK), .iSRST(iSRST),
		.frameTick(frameTick),
		.sceneColor(sceneColor), .frameTiming(sceneFrameTiming),
		.addEn(sceneAddEn), .subEn(sceneSubEn), .sceneRst(sceneRst),
		.pixelData(pixelData), .pixelValid(pixelValid),
		.pixelOut(pixelOut), .pixelOutValid(pixelOutValid),
		.alphaMax(alphaMax), .alphaMin(alphaMin)
	);

endmodule

`default_nettype wire
